//--- hw/spi_mon_pkg.sv
// ################################################
// SPI monitor program format
// OPTIONS byte layout, memory sizes and sleep timing
// ################################################

package spi_mon_pkg;

   // Instruction memory is byte wide
   localparam int IMEM_AW = 8;           // 256 program bytes
   localparam int DMEM_AW = 7;           // 128 readback words

   // Sleep between passes in units of 2**SLEEP_SHIFT clocks
   // Kept small here so a full sleep fits in a short simulation
   localparam int SLEEP_SHIFT = 4;
   localparam int SLEEP_CNT_W = SLEEP_SHIFT + 8;   // Room for the 8-bit sleep setting

   // One OPTIONS byte plus four command bytes, MSB first
   localparam int INSTR_BYTES = 5;

   // OPTIONS byte
   //   [7:6] rsvd
   //   [5]   end of pass
   //   [4:1] target lane
   //   [0]   command returns data
   typedef struct packed {
      logic [1:0] rsvd;          // Reserved
      logic       end_stream;    // Last instruction of the pass
      logic [3:0] sel;           // Target lane number
      logic       rnw;           // Read back the response
   } spi_opt_t;

endpackage : spi_mon_pkg

//--- hw/spi_bus_pkg.sv
// ################################################
// SPI lane bus definitions
// Lane count, SCLK divider and lane command/response
// ################################################

package spi_bus_pkg;

   localparam int N_LANES  = 4;                       // One lane per SPI target
   localparam int SCLK_DIV = 2;                       // Clocks per SCLK half period
   localparam int DIV_W    = $clog2(SCLK_DIV + 1);    // Half period counter width

   // Start to rsp.valid in clocks
   // 32 bits of two half periods each, then cs_n release and the response cycle
   localparam int LANE_LAT = 64 * SCLK_DIV + 2;

   typedef struct packed {
      logic [31:0] data;         // Frame shifted out MSB first
      logic        rnw;          // Return MISO data
   } spi_cmd_t;

   typedef struct packed {
      logic [31:0] rdata;        // Frame captured from MISO
      logic        valid;        // One-cycle strobe
   } spi_rsp_t;

endpackage : spi_bus_pkg

//--- hw/spi_mon_seq.sv
// ################################################
// SPI monitor sequencer
// Walks the program RAM, decodes each instruction and
// dispatches it to its lane, then sleeps between passes
// ################################################

`timescale 1ns/100ps

module spi_mon_seq
   import spi_mon_pkg::*;
   import spi_bus_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                en,            // Run the program
   input  logic [7:0]          sleep,         // Pass interval in sleep units
   input  logic                imem_we,       // Host program write
   input  logic [IMEM_AW-1:0]  imem_waddr,
   input  logic [7:0]          imem_wdata,
   input  logic [N_LANES-1:0]  lane_busy,
   output logic [N_LANES-1:0]  lane_start,    // One-cycle, one-hot
   output spi_cmd_t            lane_cmd,      // Shared by all lanes
   output logic                pass_restart   // New pass, clear readback address
);

   typedef enum logic [1:0] {
      S_FETCH,                   // Reading the five instruction bytes
      S_PEND,                    // Command waiting for its lane
      S_DRAIN,                   // END issued, waiting for lanes to go idle
      S_SLEEP                    // Pass interval
   } seq_state_t;

   logic [7:0]             imem [2**IMEM_AW];
   logic [7:0]             imem_q;        // Synchronous read data
   seq_state_t             state;
   logic [IMEM_AW-1:0]     iaddr;         // Fetch pointer
   logic [2:0]             issue_cnt;     // Bytes requested for this instruction
   logic                   rd_vld;        // imem_q holds a requested byte
   logic [2:0]             rd_idx;        // Which byte of the instruction
   spi_opt_t               opt;
   logic [31:0]            cmd_data;
   logic [SLEEP_CNT_W-1:0] sleep_cnt;
   logic [N_LANES-1:0]     sel_hot;
   logic                   sel_busy;
   logic                   go;

   // Program RAM, host writes only while stopped
   always_ff @(posedge clk) begin
      if (imem_we && !en)
         imem[imem_waddr] <= imem_wdata;
      imem_q <= imem[iaddr];
   end

   // Decode of SEL against the lane set
   always_comb begin
      sel_hot  = '0;
      sel_busy = 1'b0;
      for (int i = 0; i < N_LANES; i++) begin
         if (opt.sel == 4'(i)) begin
            sel_hot[i] = 1'b1;
            sel_busy   = lane_busy[i];
         end
      end
   end

   // SEL outside the lane set has no hot bit and is dropped on dispatch
   assign go         = en && (state == S_PEND) && !sel_busy;
   assign lane_start = go ? sel_hot : '0;
   assign lane_cmd   = '{data: cmd_data, rnw: opt.rnw};

   // Instruction assembly
   always_ff @(posedge clk) begin
      if (rd_vld) begin
         if (rd_idx == 3'd0)
            opt <= spi_opt_t'(imem_q);              // OPTIONS comes first
         else
            cmd_data <= {cmd_data[23:0], imem_q};   // Command bytes MSB first
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= S_FETCH;
         iaddr        <= '0;
         issue_cnt    <= '0;
         rd_vld       <= 1'b0;
         rd_idx       <= '0;
         sleep_cnt    <= '0;
         pass_restart <= 1'b0;
      end else if (!en) begin
         state        <= S_FETCH;   // Restart from address 0 on next enable
         iaddr        <= '0;
         issue_cnt    <= '0;
         rd_vld       <= 1'b0;
         rd_idx       <= '0;
         sleep_cnt    <= '0;
         pass_restart <= 1'b0;
      end else begin
         pass_restart <= 1'b0;
         rd_vld       <= 1'b0;
         case (state)
            S_FETCH: begin
               if (issue_cnt < 3'(INSTR_BYTES)) begin
                  iaddr     <= iaddr + 1'b1;
                  issue_cnt <= issue_cnt + 1'b1;
                  rd_vld    <= 1'b1;
                  rd_idx    <= issue_cnt;
               end
               if (rd_vld && rd_idx == 3'(INSTR_BYTES - 1)) begin
                  issue_cnt <= '0;
                  state     <= S_PEND;   // Last byte lands this edge
               end
            end
            S_PEND: begin
               if (go) begin
                  if (opt.end_stream) begin
                     iaddr <= '0;        // Wrap for the next pass
                     state <= S_DRAIN;
                  end else begin
                     state <= S_FETCH;
                  end
               end
            end
            S_DRAIN: begin
               // Responses still in flight belong to this pass
               if (lane_busy == '0) begin
                  pass_restart <= 1'b1;
                  sleep_cnt    <= '0;
                  state        <= S_SLEEP;
               end
            end
            S_SLEEP: begin
               if (sleep_cnt == {sleep, {SLEEP_SHIFT{1'b1}}})
                  state <= S_FETCH;
               else
                  sleep_cnt <= sleep_cnt + 1'b1;
            end
            default: state <= S_FETCH;
         endcase
      end
   end

   // Single dispatch per cycle and only to an idle lane
   a_start_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(lane_start));
   a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (lane_start & lane_busy) == '0);

endmodule : spi_mon_seq

//--- hw/spi_lane.sv
// ################################################
// SPI lane
// Mode-0 master for one target, 32-bit frames with
// optional MISO readback
// ################################################

`timescale 1ns/100ps

module spi_lane
   import spi_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     start,     // Taken only while idle
   input  spi_cmd_t cmd,
   output logic     busy,
   output spi_rsp_t rsp,
   output logic     sclk,
   output logic     mosi,
   output logic     cs_n,
   input  logic     miso
);

   typedef enum logic [1:0] {
      L_IDLE,
      L_SHIFT,                   // 32 SCLK periods
      L_CSUP,                    // Release chip select
      L_RSP                      // Response cycle
   } lane_state_t;

   lane_state_t      state;
   logic [DIV_W-1:0] div_cnt;    // Half period counter
   logic [4:0]       bit_cnt;
   logic             tick;       // SCLK toggles this edge
   logic [31:0]      shreg;      // Outgoing frame
   logic [31:0]      rdata;      // Incoming frame
   logic             rnw_r;
   logic             rsp_valid;

   assign tick = (state == L_SHIFT) && (div_cnt == DIV_W'(SCLK_DIV - 1));
   assign rsp  = '{rdata: rdata, valid: rsp_valid};

   // Frame data paths
   always_ff @(posedge clk) begin
      if (state == L_IDLE && start) begin
         shreg <= cmd.data;
         rnw_r <= cmd.rnw;
      end else if (tick && sclk) begin
         shreg <= {shreg[30:0], 1'b0};   // Advance on falling SCLK
      end
      if (tick && !sclk)
         rdata <= {rdata[30:0], miso};   // Sample on rising SCLK
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= L_IDLE;
         busy      <= 1'b0;
         cs_n      <= 1'b1;
         sclk      <= 1'b0;
         mosi      <= 1'b0;
         div_cnt   <= '0;
         bit_cnt   <= '0;
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= 1'b0;
         case (state)
            L_IDLE: begin
               if (start) begin
                  state   <= L_SHIFT;
                  busy    <= 1'b1;
                  cs_n    <= 1'b0;
                  mosi    <= cmd.data[31];   // First bit set up before SCLK rises
                  div_cnt <= '0;
                  bit_cnt <= '0;
               end
            end
            L_SHIFT: begin
               if (tick) begin
                  div_cnt <= '0;
                  sclk    <= ~sclk;
                  if (sclk) begin
                     if (bit_cnt == 5'd31) begin
                        state <= L_CSUP;
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        mosi    <= shreg[30];   // Next bit follows the shift
                     end
                  end
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            L_CSUP: begin
               cs_n      <= 1'b1;
               rsp_valid <= rnw_r;   // Writes give no response
               state     <= L_RSP;
            end
            L_RSP: begin
               busy  <= 1'b0;
               state <= L_IDLE;
            end
            default: state <= L_IDLE;
         endcase
      end
   end

   // A response belongs to a frame in progress
   a_valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(rsp.valid) |-> busy && cs_n);

endmodule : spi_lane

//--- hw/spi_rdata_collect.sv
// ################################################
// SPI readback collector
// Stores lane responses in issue order into the
// readback RAM and serves host reads
// ################################################

`timescale 1ns/100ps

module spi_rdata_collect
   import spi_mon_pkg::*;
   import spi_bus_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        en,
   input  logic                        pass_restart,   // Back to address 0
   input  spi_rsp_t [N_LANES-1:0]      rsp,
   input  logic [DMEM_AW-1:0]          rd_addr,
   output logic [31:0]                 rd_data         // One cycle after rd_addr
);

   logic [31:0]        ram [2**DMEM_AW];
   logic [N_LANES-1:0] lane_vld;
   logic [31:0]        wr_data;
   logic               wr_en;
   logic [DMEM_AW-1:0] wr_addr;

   // Equal lane latency keeps valids one-hot
   always_comb begin
      wr_data = '0;
      for (int i = 0; i < N_LANES; i++) begin
         lane_vld[i] = rsp[i].valid;
         if (rsp[i].valid)
            wr_data = wr_data | rsp[i].rdata;
      end
   end

   assign wr_en = en && (lane_vld != '0);

   // Write pointer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         wr_addr <= '0;
      else if (!en || pass_restart)
         wr_addr <= '0;
      else if (wr_en)
         wr_addr <= wr_addr + 1'b1;   // Wraps past 128 reads
   end

   // Readback RAM
   always_ff @(posedge clk) begin
      if (wr_en)
         ram[wr_addr] <= wr_data;
      rd_data <= ram[rd_addr];
   end

   // Sequencer start ordering reaches here as one response per cycle
   a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(lane_vld));

endmodule : spi_rdata_collect

//--- hw/spi_mon_top.sv
// ################################################
// SPI monitor top
// Sequencer, four SPI lanes and readback collector
// ################################################

`timescale 1ns/100ps

module spi_mon_top
   import spi_mon_pkg::*;
   import spi_bus_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                en,
   input  logic [7:0]          sleep,
   input  logic                imem_we,
   input  logic [IMEM_AW-1:0]  imem_waddr,
   input  logic [7:0]          imem_wdata,
   input  logic [DMEM_AW-1:0]  rd_addr,
   output logic [31:0]         rd_data,
   output logic [N_LANES-1:0]  spi_sclk,
   output logic [N_LANES-1:0]  spi_mosi,
   output logic [N_LANES-1:0]  spi_cs_n,
   input  logic [N_LANES-1:0]  spi_miso
);

   logic [N_LANES-1:0]     lane_start;
   logic [N_LANES-1:0]     lane_busy;
   spi_cmd_t               lane_cmd;
   spi_rsp_t [N_LANES-1:0] lane_rsp;
   logic                   pass_restart;

   spi_mon_seq u_seq (
      .clk          (clk),
      .rst_n        (rst_n),
      .en           (en),
      .sleep        (sleep),
      .imem_we      (imem_we),
      .imem_waddr   (imem_waddr),
      .imem_wdata   (imem_wdata),
      .lane_busy    (lane_busy),
      .lane_start   (lane_start),
      .lane_cmd     (lane_cmd),
      .pass_restart (pass_restart)
   );

   // One master per target
   for (genvar i = 0; i < N_LANES; i++) begin : g_lane
      spi_lane u_lane (
         .clk   (clk),
         .rst_n (rst_n),
         .start (lane_start[i]),
         .cmd   (lane_cmd),
         .busy  (lane_busy[i]),
         .rsp   (lane_rsp[i]),
         .sclk  (spi_sclk[i]),
         .mosi  (spi_mosi[i]),
         .cs_n  (spi_cs_n[i]),
         .miso  (spi_miso[i])
      );
   end

   spi_rdata_collect u_collect (
      .clk          (clk),
      .rst_n        (rst_n),
      .en           (en),
      .pass_restart (pass_restart),
      .rsp          (lane_rsp),
      .rd_addr      (rd_addr),
      .rd_data      (rd_data)
   );

endmodule : spi_mon_top

//--- verification/spi_target_model.sv
// ################################################
// SPI target model
// Mode-0 slave that captures each MOSI frame and
// answers with ~frame ^ lane pattern on MISO
// ################################################

`timescale 1ns/100ps

module spi_target_model #(
   parameter logic [7:0] LANE_ID = 8'd0   // Replicated into every response byte
) (
   input  logic        sclk,
   input  logic        mosi,
   input  logic        cs_n,
   output logic        miso,
   output logic [31:0] frame,       // Last complete frame
   output logic [7:0]  frame_cnt    // Complete frames seen
);

   logic [31:0] shin;
   logic [5:0]  bit_idx;              // Rising SCLK edges in this frame
   logic [31:0] pat;

   initial begin
      shin      = '0;
      bit_idx   = '0;
      frame     = '0;
      frame_cnt = '0;
   end

   assign pat = {4{LANE_ID}};

   // Response bit follows the bit now on MOSI, ready before SCLK rises
   assign miso = cs_n ? 1'b0 : (~mosi ^ pat[5'd31 - bit_idx[4:0]]);

   // Capture on rising SCLK, restart on chip select
   always @(posedge sclk or negedge cs_n) begin
      if (sclk) begin
         shin    <= {shin[30:0], mosi};
         bit_idx <= bit_idx + 1'b1;
      end else begin
         bit_idx <= '0;
      end
   end

   // Only a full 32-bit frame counts
   always @(posedge cs_n) begin
      if (bit_idx == 6'd32) begin
         frame     <= shin;
         frame_cnt <= frame_cnt + 1'b1;
      end
   end

endmodule : spi_target_model

//--- verification/spi_mon_tb.sv
// ################################################
// SPI monitor testbench
// Loads program tables, follows frames on each target
// and checks the readback RAM after every pass
// ################################################

`timescale 1ns/100ps

module spi_mon_tb
   import spi_mon_pkg::*;
   import spi_bus_pkg::*;
();

   typedef struct packed {
      logic [3:0]  sel;
      logic        rnw;
      logic        last;              // END bit
      logic [31:0] cmd;
   } row_t;

   localparam int N_ROWS = 14;        // Rows 0..7 program A, 8..13 program B
   localparam int TMO    = 6000;      // Cycles per wait

   logic                clk;
   logic                rst_n;
   logic                en;
   logic [7:0]          sleep;
   logic                imem_we;
   logic [IMEM_AW-1:0]  imem_waddr;
   logic [7:0]          imem_wdata;
   logic [DMEM_AW-1:0]  rd_addr;
   logic [31:0]         rd_data;
   logic [N_LANES-1:0]  spi_sclk;
   logic [N_LANES-1:0]  spi_mosi;
   logic [N_LANES-1:0]  spi_cs_n;
   logic [N_LANES-1:0]  spi_miso;
   logic [31:0]         tgt_frame [N_LANES];
   logic [7:0]          tgt_cnt [N_LANES];

   row_t        tab [N_ROWS];
   logic [31:0] rx [N_LANES][64];     // Frames in arrival order per lane
   logic [7:0]  seen [N_LANES];
   logic [7:0]  base [N_LANES];       // seen[] at start of a pass
   logic [15:0] lfsr;
   logic        overlap_seen;

   spi_mon_top UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .en         (en),
      .sleep      (sleep),
      .imem_we    (imem_we),
      .imem_waddr (imem_waddr),
      .imem_wdata (imem_wdata),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .spi_sclk   (spi_sclk),
      .spi_mosi   (spi_mosi),
      .spi_cs_n   (spi_cs_n),
      .spi_miso   (spi_miso)
   );

   for (genvar g = 0; g < N_LANES; g++) begin : g_tgt
      spi_target_model #(.LANE_ID(8'(g))) u_tgt (
         .sclk      (spi_sclk[g]),
         .mosi      (spi_mosi[g]),
         .cs_n      (spi_cs_n[g]),
         .miso      (spi_miso[g]),
         .frame     (tgt_frame[g]),
         .frame_cnt (tgt_cnt[g])
      );
   end

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Frame log and overlap watch
   always @(posedge clk) begin
      for (int l = 0; l < N_LANES; l++) begin
         if (tgt_cnt[l] != seen[l]) begin
            rx[l][seen[l][5:0]] = tgt_frame[l];
            seen[l] = seen[l] + 1'b1;
         end
      end
      if (!$onehot0(~spi_cs_n))
         overlap_seen = 1'b1;        // Two lanes in a frame at once
   end

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_cmd(input string name, input spi_cmd_t got, input spi_cmd_t exp);
      if (got.data !== exp.data)
         fail_stop($sformatf("FAIL t=%0t %s got %h exp %h", $time, name, got.data, exp.data));
   endtask

   task automatic check_rdata(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         fail_stop($sformatf("FAIL t=%0t %s got %h exp %h", $time, name, got, exp));
   endtask

   task automatic check_cs(input string name, input logic [N_LANES-1:0] got,
                           input logic [N_LANES-1:0] exp);
      if (got !== exp)
         fail_stop($sformatf("FAIL t=%0t %s got %b exp %b", $time, name, got, exp));
   endtask

   // Fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit
   function automatic logic [31:0] draw_word();
      logic [31:0] w;
      logic        fb;
      w = '0;
      for (int b = 0; b < 32; b++) begin
         w    = {w[30:0], lfsr[15]};
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
      end
      return w;
   endfunction

   function automatic logic [31:0] exp_rsp(input row_t r);
      return ~r.cmd ^ {4{4'h0, r.sel}};     // Target answer rule
   endfunction

   task automatic write_byte(input logic [IMEM_AW-1:0] a, input logic [7:0] d);
      @(negedge clk);
      imem_we    = 1'b1;
      imem_waddr = a;
      imem_wdata = d;
   endtask

   task automatic load_program(input int first, input int last);
      spi_opt_t           opt;
      logic [IMEM_AW-1:0] a;
      a = '0;
      for (int r = first; r <= last; r++) begin
         opt = '{rsvd: 2'b00, end_stream: tab[r].last, sel: tab[r].sel, rnw: tab[r].rnw};
         write_byte(a, opt);
         a = a + 1'b1;
         for (int k = 3; k >= 0; k--) begin
            write_byte(a, tab[r].cmd[k*8 +: 8]);   // MSB first
            a = a + 1'b1;
         end
      end
      @(negedge clk);
      imem_we = 1'b0;
   endtask

   task automatic read_ram(input int a, output logic [31:0] d);
      @(negedge clk);
      rd_addr = DMEM_AW'(a);
      @(negedge clk);
      d = rd_data;
   endtask

   function automatic int total_seen();
      int s;
      s = 0;
      for (int l = 0; l < N_LANES; l++)
         s += int'(seen[l]);
      return s;
   endfunction

   task automatic snap_base();
      for (int l = 0; l < N_LANES; l++)
         base[l] = seen[l];
   endtask

   task automatic wait_frames(input int n);
      int t;
      t = 0;
      while (total_seen() < n) begin
         @(negedge clk);
         t++;
         if (t > TMO)
            fail_stop($sformatf("Timed out waiting for %0d SPI frames", n));
      end
   endtask

   task automatic wait_cs_idle();
      int t;
      t = 0;
      while (spi_cs_n !== '1) begin
         @(negedge clk);
         t++;
         if (t > TMO)
            fail_stop("Timed out waiting for all chip selects to go high");
      end
      repeat (3) @(negedge clk);   // Response and RAM write
   endtask

   // Chip selects stay high for longer than a full sleep and fetch
   task automatic hold_cs_idle(input int n);
      for (int c = 0; c < n; c++) begin
         @(negedge clk);
         check_cs("spi_cs_n", spi_cs_n, '1);
      end
   endtask

   // Frames per lane in table order, then the rnw responses from address 0
   task automatic check_pass(input int first, input int last);
      int         k [N_LANES];
      int         n_rd;
      spi_cmd_t   got;
      spi_cmd_t   exp;
      logic [31:0] d;
      int         l;
      n_rd = 0;
      for (int i = 0; i < N_LANES; i++)
         k[i] = 0;
      for (int r = first; r <= last; r++) begin
         l   = int'(tab[r].sel);
         exp = '{data: tab[r].cmd, rnw: tab[r].rnw};
         got = '{data: rx[l][6'(int'(base[l]) + k[l])], rnw: tab[r].rnw};
         check_cmd($sformatf("lane%0d frame%0d", l, k[l]), got, exp);
         k[l]++;
      end
      for (int i = 0; i < N_LANES; i++)
         if (int'(seen[i] - base[i]) != k[i])
            fail_stop($sformatf("Lane %0d received %0d frames, expected %0d",
                                i, seen[i] - base[i], k[i]));
      for (int r = first; r <= last; r++) begin
         if (tab[r].rnw) begin
            read_ram(n_rd, d);
            check_rdata($sformatf("rd_data[%0d]", n_rd), d, exp_rsp(tab[r]));
            n_rd++;
         end
      end
   endtask

   initial begin
      logic [31:0] d;
      rst_n        = 1'b0;
      en           = 1'b0;
      sleep        = 8'd2;
      imem_we      = 1'b0;
      imem_waddr   = '0;
      imem_wdata   = '0;
      rd_addr      = '0;
      lfsr         = 16'd41;
      overlap_seen = 1'b0;
      for (int l = 0; l < N_LANES; l++)
         seen[l] = '0;

      // sel, rnw, end; commands drawn below
      tab[0]  = '{4'd0, 1'b1, 1'b0, 32'h0};
      tab[1]  = '{4'd1, 1'b0, 1'b0, 32'h0};
      tab[2]  = '{4'd1, 1'b1, 1'b0, 32'h0};   // Same lane back to back
      tab[3]  = '{4'd1, 1'b1, 1'b0, 32'h0};
      tab[4]  = '{4'd2, 1'b1, 1'b0, 32'h0};
      tab[5]  = '{4'd3, 1'b0, 1'b0, 32'h0};
      tab[6]  = '{4'd3, 1'b1, 1'b0, 32'h0};
      tab[7]  = '{4'd0, 1'b0, 1'b1, 32'h0};
      tab[8]  = '{4'd3, 1'b1, 1'b0, 32'h0};
      tab[9]  = '{4'd2, 1'b0, 1'b0, 32'h0};
      tab[10] = '{4'd2, 1'b1, 1'b0, 32'h0};
      tab[11] = '{4'd0, 1'b0, 1'b0, 32'h0};
      tab[12] = '{4'd1, 1'b1, 1'b0, 32'h0};
      tab[13] = '{4'd1, 1'b0, 1'b1, 32'h0};
      for (int r = 0; r < N_ROWS; r++)
         tab[r].cmd = draw_word();

      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_cs("spi_cs_n", spi_cs_n, '1);

      // Program A, first pass
      load_program(0, 7);
      snap_base();
      @(negedge clk);
      en = 1'b1;
      wait_frames(total_seen() + 8);
      wait_cs_idle();
      check_pass(0, 7);
      if (!overlap_seen)
         fail_stop("No two lanes were ever active at the same time");

      // Second pass after the sleep
      snap_base();
      wait_frames(total_seen() + 8);
      wait_cs_idle();
      check_pass(0, 7);

      @(negedge clk);
      en = 1'b0;
      wait_cs_idle();
      hold_cs_idle((int'(sleep) + 2) << SLEEP_SHIFT);

      // Program B, fewer reads than A
      load_program(8, 13);
      snap_base();
      @(negedge clk);
      en = 1'b1;
      wait_frames(total_seen() + 6);
      wait_cs_idle();
      check_pass(8, 13);

      // Second pass of B must rewrite from address 0
      snap_base();
      wait_frames(total_seen() + 6);
      wait_cs_idle();
      check_pass(8, 13);
      read_ram(3, d);                 // Left over from program A
      check_rdata("rd_data[3]", d, exp_rsp(tab[4]));

      @(negedge clk);
      en = 1'b0;
      wait_cs_idle();
      hold_cs_idle((int'(sleep) + 2) << SLEEP_SHIFT);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule : spi_mon_tb

//--- compile.f
hw/spi_mon_pkg.sv
hw/spi_bus_pkg.sv
hw/spi_mon_seq.sv
hw/spi_lane.sv
hw/spi_rdata_collect.sv
hw/spi_mon_top.sv
verification/spi_target_model.sv
verification/spi_mon_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI monitor simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f compile.f \
   --top-module spi_mon_tb \
   -o spi_mon_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out="$(./obj_dir/spi_mon_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
   exit 0
fi
echo "Pass message not found"
exit 1
